/* src/alt_io_pkg.sv */
// Height sample struct and height ceiling constant
`default_nettype none

package alt_io_pkg;

	// Highest height the ranger reports, in mm
	localparam logic signed [15:0] ALT_MAX_MM = 16'sd5000;

	// One height measurement
	// Valid is a single cycle strobe
	typedef struct packed {
		logic valid;
		// Millimetres above the sensor
		logic signed [15:0] height;
	} alt_sample_t;

endpackage

`default_nettype wire

/* src/alt_ctrl_pkg.sv */
// Controller gain and throttle structs, throttle ceiling and scaling shifts
`default_nettype none

package alt_ctrl_pkg;

	// Clamp for the integral and the output
	// Also the shortest legal PWM period
	localparam int THROTTLE_MAX = 12240;

	// Gains are in units of 1/16
	localparam int GAIN_SHIFT = 4;

	// Command counts are 16 mm each
	localparam int CMD_SHIFT = 4;

	// PI gains, both unsigned
	typedef struct packed {
		logic [7:0] kp;
		logic [7:0] ki;
	} pi_gains_t;

	// Controller result
	// Value stays in 0 to THROTTLE_MAX
	typedef struct packed {
		logic valid;
		logic [14:0] value;
	} throttle_t;

endpackage

`default_nettype wire

/* src/echo_ranger.sv */
// Echo ranger module timing the echo pulse into saturated height samples
`timescale 1ns/1ns
`default_nettype none

module echo_ranger #(
	// Clocks per millimetre of echo time
	parameter int TICKS_PER_MM = 6
) (
	input wire clk,
	input wire reset,
	// Raw echo level, asynchronous to clk
	input wire echo,
	output alt_io_pkg::alt_sample_t sample
);

	localparam int PRE_W = (TICKS_PER_MM > 1) ? $clog2(TICKS_PER_MM) : 1;

	// Synchronizer stages and delayed copy for edge detect
	logic echo_meta;
	logic echo_sync;
	logic echo_prev;
	logic echo_fall;

	// Clocks within the current millimetre
	logic [PRE_W-1:0] prescale;
	// Whole millimetres so far
	logic signed [15:0] height_cnt;
	logic mm_tick;

	always_ff @(posedge clk) begin
		if (reset) begin
			echo_meta <= 1'b0;
			echo_sync <= 1'b0;
			echo_prev <= 1'b0;
		end else begin
			echo_meta <= echo;
			echo_sync <= echo_meta;
			echo_prev <= echo_sync;
		end
	end

	// First low cycle after a high run
	assign echo_fall = echo_prev & ~echo_sync;
	assign mm_tick = (prescale == PRE_W'(TICKS_PER_MM - 1));

	// Width counters, cleared once the sample is taken
	always_ff @(posedge clk) begin
		if (reset || echo_fall) begin
			prescale <= '0;
			height_cnt <= '0;
		end else if (echo_sync) begin
			if (mm_tick) begin
				prescale <= '0;
				// Hold at the ceiling
				if (height_cnt < alt_io_pkg::ALT_MAX_MM) begin
					height_cnt <= height_cnt + 16'sd1;
				end
			end else begin
				prescale <= prescale + 1'b1;
			end
		end
	end

	// One sample per pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			sample.valid <= 1'b0;
		end else begin
			sample.valid <= echo_fall;
		end
		if (echo_fall) begin
			sample.height <= height_cnt;
		end
	end

	// Reported height never above the ceiling
	a_height_cap: assert property (@(posedge clk) disable iff (reset)
		sample.valid |-> (sample.height <= alt_io_pkg::ALT_MAX_MM));

endmodule

`default_nettype wire

/* src/pid_altitude.sv */
// PI altitude controller module with clamped integral and clamped output
`timescale 1ns/1ns
`default_nettype none

module pid_altitude (
	input wire clk,
	input wire reset,
	input wire alt_io_pkg::alt_sample_t sample,
	// Commanded height in 16 mm steps
	input wire [7:0] command,
	input wire alt_ctrl_pkg::pi_gains_t gains,
	output alt_ctrl_pkg::throttle_t throttle
);

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_ONE,
		ST_TWO
	} state_t;

	state_t state;

	// Command scaled to mm, 0 to 4080
	logic signed [15:0] command_mm;
	// Roughly -5000 to 4080
	logic signed [15:0] error;
	logic signed [31:0] p_product;
	logic signed [31:0] i_product;

	// Terms after the 1/16 gain scaling
	logic signed [31:0] p_term;
	logic signed [31:0] i_term;
	// Integral, always kept inside the clamp range
	logic signed [31:0] accum;
	// Stage one sums, before clamping
	logic signed [31:0] accum_cand;
	logic signed [31:0] out_cand;

	// Saturate into 0 to THROTTLE_MAX
	function automatic logic signed [31:0] clamp_throttle(input logic signed [31:0] x);
		if (x < 0) begin
			return 32'sd0;
		end else if (x > alt_ctrl_pkg::THROTTLE_MAX) begin
			return alt_ctrl_pkg::THROTTLE_MAX;
		end
		return x;
	endfunction

	assign command_mm = 16'(command) << alt_ctrl_pkg::CMD_SHIFT;
	assign error = command_mm - sample.height;

	// Gains zero extended so the products stay signed
	assign p_product = error * $signed({1'b0, gains.kp});
	assign i_product = error * $signed({1'b0, gains.ki});

	// Sequencer and control state
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_WAIT;
			throttle.valid <= 1'b0;
			accum <= '0;
		end else begin
			throttle.valid <= 1'b0;
			case (state)
				ST_WAIT: begin
					if (sample.valid) begin
						state <= ST_ONE;
					end
				end
				ST_ONE: begin
					state <= ST_TWO;
				end
				ST_TWO: begin
					state <= ST_WAIT;
					accum <= clamp_throttle(accum_cand);
					throttle.valid <= 1'b1;
				end
				default: begin
					state <= ST_WAIT;
				end
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		// Capture terms on an accepted sample only
		if (state == ST_WAIT && sample.valid) begin
			p_term <= p_product >>> alt_ctrl_pkg::GAIN_SHIFT;
			i_term <= i_product >>> alt_ctrl_pkg::GAIN_SHIFT;
		end
		if (state == ST_ONE) begin
			accum_cand <= accum + i_term;
			out_cand <= p_term + accum + i_term;
		end
		if (state == ST_TWO) begin
			throttle.value <= 15'(clamp_throttle(out_cand));
		end
	end

	// Only one result in flight at a time
	a_single_strobe: assert property (@(posedge clk) disable iff (reset)
		throttle.valid |=> !throttle.valid);

	// Anti-windup holds across every update
	a_accum_range: assert property (@(posedge clk) disable iff (reset)
		(accum >= 0) && (accum <= alt_ctrl_pkg::THROTTLE_MAX));

endmodule

`default_nettype wire

/* src/throttle_pwm.sv */
// Throttle PWM module with duty reload at the period boundary
`timescale 1ns/1ns
`default_nettype none

module throttle_pwm #(
	// Clocks per PWM period
	parameter int PWM_PERIOD = 12288
) (
	input wire clk,
	input wire reset,
	input wire alt_ctrl_pkg::throttle_t throttle,
	// Motor drive level
	output logic pwm
);

	localparam int CNT_W = $clog2(PWM_PERIOD);

	// Full scale throttle must fit in one period
	if (PWM_PERIOD < alt_ctrl_pkg::THROTTLE_MAX) begin : g_period_check
		$error("PWM_PERIOD is shorter than THROTTLE_MAX");
	end

	logic [CNT_W-1:0] period_cnt;
	logic period_end;
	// Latest throttle waiting for the wrap
	logic [14:0] duty_pending;
	// Duty of the running period
	logic [14:0] duty_active;

	assign period_end = (period_cnt == CNT_W'(PWM_PERIOD - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			period_cnt <= '0;
			duty_pending <= '0;
			duty_active <= '0;
		end else begin
			if (throttle.valid) begin
				duty_pending <= throttle.value;
			end
			if (period_end) begin
				period_cnt <= '0;
				// Swap only here so no pulse is cut short
				duty_active <= duty_pending;
			end else begin
				period_cnt <= period_cnt + 1'b1;
			end
		end
	end

	// High for the first duty_active clocks of each period
	assign pwm = (32'(period_cnt) < 32'(duty_active));

	a_zero_duty: assert property (@(posedge clk) disable iff (reset)
		(duty_active == '0) |-> !pwm);

endmodule

`default_nettype wire

/* src/alt_hold_top.sv */
// Altitude hold top module joining ranger, PI controller and PWM
`timescale 1ns/1ns
`default_nettype none

module alt_hold_top #(
	// Clocks per mm of echo time
	parameter int TICKS_PER_MM = 6,
	// Clocks per PWM period
	parameter int PWM_PERIOD = 12288
) (
	input wire clk,
	input wire reset,
	// Echo level from the ultrasonic sensor
	input wire echo,
	// Commanded height in 16 mm steps
	input wire [7:0] command,
	input wire alt_ctrl_pkg::pi_gains_t gains,
	// Controller result, also drives the PWM
	output alt_ctrl_pkg::throttle_t throttle,
	output logic pwm
);

	// Height samples from ranger to controller
	alt_io_pkg::alt_sample_t sample;

	echo_ranger #(
		.TICKS_PER_MM(TICKS_PER_MM)
	) ranger_i (
		.clk(clk),
		.reset(reset),
		.echo(echo),
		.sample(sample)
	);

	pid_altitude pid_i (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.command(command),
		.gains(gains),
		.throttle(throttle)
	);

	throttle_pwm #(
		.PWM_PERIOD(PWM_PERIOD)
	) pwm_i (
		.clk(clk),
		.reset(reset),
		.throttle(throttle),
		.pwm(pwm)
	);

endmodule

`default_nettype wire

/* verif/alt_hold_tb.sv */
// Altitude hold testbench with echo stimulus, PI reference model and checking assertions
`timescale 1ns/1ns
`default_nettype none

module alt_hold_tb;

	localparam int TICKS = 6;
	localparam int PERIOD = 12288;
	// Negedges allowed from echo fall to result
	localparam int RESULT_WAIT = 40;

	logic clk;
	logic reset;
	logic echo;
	logic [7:0] command;
	alt_ctrl_pkg::pi_gains_t gains;
	alt_ctrl_pkg::throttle_t throttle;
	logic pwm;

	// Model state
	int model_acc;
	int exp_value;
	logic exp_pending;
	logic [31:0] seed;
	int mismatch_count;
	int other_count;
	int results_seen;
	int periods_checked;

	// PWM model, one period behind the DUT counter
	int pcnt;
	int hi_cnt;
	int hi_total;
	int duty_pend;
	int duty_act;
	int duty_checked;
	logic period_done;

	alt_hold_top #(
		.TICKS_PER_MM(TICKS),
		.PWM_PERIOD(PERIOD)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.echo(echo),
		.command(command),
		.gains(gains),
		.throttle(throttle),
		.pwm(pwm)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Saturate into 0 to THROTTLE_MAX
	function automatic int limit_throttle(input int x);
		if (x < 0) begin
			return 0;
		end else if (x > alt_ctrl_pkg::THROTTLE_MAX) begin
			return alt_ctrl_pkg::THROTTLE_MAX;
		end
		return x;
	endfunction

	// Duty per period from the predicted throttle values
	always @(posedge clk) begin
		if (reset) begin
			pcnt <= 0;
			hi_cnt <= 0;
			duty_pend <= 0;
			duty_act <= 0;
			period_done <= 1'b0;
		end else begin
			if (throttle.valid) begin
				duty_pend <= exp_value;
			end
			if (pcnt == PERIOD - 1) begin
				pcnt <= 0;
				duty_act <= duty_pend;
				duty_checked <= duty_act;
				hi_total <= hi_cnt + pwm;
				hi_cnt <= 0;
				period_done <= 1'b1;
				periods_checked <= periods_checked + 1;
			end else begin
				pcnt <= pcnt + 1;
				hi_cnt <= hi_cnt + pwm;
				period_done <= 1'b0;
			end
		end
	end

	a_value: assert property (@(posedge clk) disable iff (reset)
		throttle.valid |-> (exp_pending && throttle.value == exp_value))
	else begin
		mismatch_count++;
		$display("mismatch at %0t: throttle %0d, expected %0d", $time,
			$sampled(throttle.value), $sampled(exp_value));
	end

	a_duty: assert property (@(posedge clk) disable iff (reset)
		period_done |-> (hi_total == duty_checked))
	else begin
		mismatch_count++;
		$display("mismatch at %0t: pwm high %0d cycles, expected %0d", $time,
			$sampled(hi_total), $sampled(duty_checked));
	end

	// Outputs quiet right after reset
	a_reset: assert property (@(posedge clk) $fell(reset) |-> (!pwm && !throttle.valid))
	else begin
		mismatch_count++;
		$display("mismatch at %0t: pwm or throttle valid high after reset", $time);
	end

	// One echo pulse, model prediction, then wait for the result
	task automatic issue_echo(input int width, input logic [7:0] cmd,
		input logic [7:0] kp, input logic [7:0] ki);
		int h;
		int err;
		int p;
		int i;
		int guard;
		logic got;
		@(posedge clk);
		h = width / TICKS;
		if (h > alt_io_pkg::ALT_MAX_MM) begin
			h = alt_io_pkg::ALT_MAX_MM;
		end
		err = int'(cmd) * 16 - h;
		p = (int'(kp) * err) >>> alt_ctrl_pkg::GAIN_SHIFT;
		i = (int'(ki) * err) >>> alt_ctrl_pkg::GAIN_SHIFT;
		// Output uses the old accumulator
		exp_value = limit_throttle(p + model_acc + i);
		model_acc = limit_throttle(model_acc + i);
		exp_pending = 1'b1;
		command <= cmd;
		gains.kp <= kp;
		gains.ki <= ki;
		echo <= 1'b1;
		repeat (width) @(posedge clk);
		echo <= 1'b0;
		got = 1'b0;
		guard = 0;
		while (!got && guard < RESULT_WAIT) begin
			@(negedge clk);
			got = throttle.valid;
			guard++;
		end
		if (got) begin
			results_seen++;
			@(posedge clk);
		end else begin
			other_count++;
			$display("timeout at %0t: no throttle result after the echo pulse", $time);
		end
		exp_pending = 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		echo <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		model_acc = 0;
		exp_pending = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		echo = 1'b0;
		command = '0;
		gains = '0;
		seed = 32'hcc1804bc;
		model_acc = 0;
		exp_value = 0;
		exp_pending = 1'b0;
		mismatch_count = 0;
		other_count = 0;
		results_seen = 0;
		periods_checked = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Clamp at both ends, then random P only runs
		issue_echo(6000, 8'd0, 8'd40, 8'd0);
		issue_echo(60, 8'd255, 8'd255, 8'd0);
		for (int k = 0; k < 12; k++) begin
			seed = lcg_next(seed);
			issue_echo(60 + int'(seed[30:8] % 24000), seed[7:0], seed[15:8], 8'd0);
		end

		// Windup against the clamp with a large ki
		seed = lcg_next(seed);
		for (int k = 0; k < 6; k++) begin
			issue_echo(120, 8'd200, 8'd0, {1'b1, seed[22:16]});
		end
		// Echo past the ceiling, 5100 mm raw
		issue_echo(5000 * TICKS + 600, 8'd255, 8'd8, 8'd0);
		// Descent from the clamped accumulator
		for (int k = 0; k < 6; k++) begin
			issue_echo(9000, 8'd50, 8'd0, {1'b1, seed[22:16]});
		end

		issue_echo(600, 8'd100, 8'd16, 8'd0);
		repeat (3 * PERIOD) @(posedge clk);

		// Reset partway through a period
		repeat (PERIOD / 3) @(posedge clk);
		apply_reset();
		issue_echo(600, 8'd100, 8'd16, 8'd32);
		repeat (2 * PERIOD + 10) @(posedge clk);

		if (results_seen == 0 || periods_checked == 0) begin
			other_count++;
			$display("no throttle results or pwm periods were checked");
		end
		$display("results %0d, pwm periods %0d, mismatches %0d, other errors %0d",
			results_seen, periods_checked, mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* alt_hold.f */
src/alt_io_pkg.sv
src/alt_ctrl_pkg.sv
src/echo_ranger.sv
src/pid_altitude.sv
src/throttle_pwm.sv
src/alt_hold_top.sv
verif/alt_hold_tb.sv

/* Bender.yml */
package:
  name: alt_hold

sources:
  - src/alt_io_pkg.sv
  - src/alt_ctrl_pkg.sv
  - src/echo_ranger.sv
  - src/pid_altitude.sv
  - src/throttle_pwm.sv
  - src/alt_hold_top.sv
  - target: test
    files:
      - verif/alt_hold_tb.sv
